// ==== logic/lc4_macros.svh ====
`ifndef LC4_MACROS_SVH
`define LC4_MACROS_SVH

// datapath and address width
`define LC4_WORD_W 16

// register select width and count
`define LC4_REG_W 3
`define LC4_NUM_REGS 8

// first fetch address after reset
`define LC4_BOOT_PC 16'h8200

// opcode field inside an instruction word
`define LC4_OPC_MSB 15
`define LC4_OPC_LSB 12

// cycles before the testbench gives up on a program
`define LC4_RUN_LIMIT 2000

`endif

// ==== logic/lc4_pkg.sv ====
`include "lc4_macros.svh"

package lc4_pkg;

   // top nibble of the instruction, kept subset only
   typedef enum logic [3:0] {
      OPC_BR    = 4'h0,
      OPC_ARITH = 4'h1,
      OPC_LOGIC = 4'h5,
      OPC_LDR   = 4'h6,
      OPC_STR   = 4'h7,
      OPC_CONST = 4'h9
   } opcode_t;

   // order matters: {is_logic, sub-op bit 4} indexes this
   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_OR  = 2'd3
   } alu_op_t;

   typedef enum logic [1:0] {
      STALL_NONE   = 2'd0,
      STALL_FLUSH  = 2'd2, // squashed by a taken branch or reset
      STALL_HAZARD = 2'd3  // bubble behind a pending register or nzp write
   } stall_t;

   // second ALU operand source
   typedef enum logic [1:0] {
      IMM_REG    = 2'd0, // rt
      IMM_OFF6   = 2'd1, // sext(insn[5:0]), load/store address
      IMM_CONST9 = 2'd2  // sext(insn[8:0]) replaces the result
   } imm_sel_t;

   typedef struct packed {
      logic [`LC4_REG_W-1:0] rs_sel;
      logic [`LC4_REG_W-1:0] rt_sel;
      logic                  rs_re;
      logic                  rt_re;
      logic [`LC4_REG_W-1:0] rd_sel;
      logic                  rf_we;
      logic                  nzp_we;
      logic                  is_load;
      logic                  is_store;
      logic                  is_branch;
      alu_op_t               alu_op;
      imm_sel_t              imm_sel;
   } ctrl_t;

   // one pipeline slot; value is rt in execute, result/address in memory,
   // writeback data in writeback
   typedef struct packed {
      logic [`LC4_WORD_W-1:0] pc;
      logic [`LC4_WORD_W-1:0] insn;
      ctrl_t                  ctrl;
      stall_t                 stall;
      logic [`LC4_WORD_W-1:0] value;
   } stage_t;

   typedef struct packed {
      stall_t                 stall;
      logic [`LC4_WORD_W-1:0] pc;
      logic [`LC4_WORD_W-1:0] insn;
      logic                   regfile_we;
      logic [`LC4_REG_W-1:0]  regfile_wsel;
      logic [`LC4_WORD_W-1:0] regfile_data;
      logic                   nzp_we;
      logic [2:0]             nzp_bits;
      logic                   dmem_we;
      logic [`LC4_WORD_W-1:0] dmem_addr;
      logic [`LC4_WORD_W-1:0] dmem_data;
   } wb_trace_t;

   function automatic logic [2:0] nzp_of(input logic [`LC4_WORD_W-1:0] word);
      if (word[`LC4_WORD_W-1]) begin
         return 3'b100;
      end else if (word == '0) begin
         return 3'b010;
      end else begin
         return 3'b001;
      end
   endfunction

endpackage

// ==== logic/lc4_pc_counter.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_pc_counter (
   input  logic                   gwe,
   input  logic                   i_reset,
   input  logic                   i_stall,    // decode is holding
   input  logic                   i_redirect, // taken branch in execute
   input  logic [`LC4_WORD_W-1:0] i_target,
   output logic [`LC4_WORD_W-1:0] o_pc
);

   logic [`LC4_WORD_W-1:0] pc_q;
   logic [`LC4_WORD_W-1:0] pc_next;

   // redirect wins: the stalled decode slot is younger than the branch
   always_comb begin
      if (i_redirect) begin
         pc_next = i_target;
      end else if (i_stall) begin
         pc_next = pc_q;
      end else begin
         pc_next = pc_q + 1'b1;
      end
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc_q <= `LC4_BOOT_PC;
      end else begin
         pc_q <= pc_next;
      end
   end

   assign o_pc = pc_q;

endmodule

// ==== logic/lc4_decoder.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_decoder
   import lc4_pkg::*;
(
   input  logic [`LC4_WORD_W-1:0] i_insn,
   output ctrl_t                  o_ctrl
);

   opcode_t opc;
   logic    rr_sub_ok; // sub-op is one of the two kept register forms

   assign opc       = opcode_t'(i_insn[`LC4_OPC_MSB:`LC4_OPC_LSB]);
   assign rr_sub_ok = (i_insn[5:3] == 3'b000) || (i_insn[5:3] == 3'b010);

   always_comb begin
      // field positions are fixed across formats, enables decide use
      o_ctrl         = '0;
      o_ctrl.rs_sel  = i_insn[8:6];
      o_ctrl.rt_sel  = i_insn[2:0];
      o_ctrl.rd_sel  = i_insn[11:9];
      o_ctrl.alu_op  = ALU_ADD;
      o_ctrl.imm_sel = IMM_REG;

      case (opc)
         OPC_BR: begin
            o_ctrl.is_branch = |i_insn[11:9]; // empty mask is a nop
         end
         OPC_ARITH, OPC_LOGIC: begin
            if (rr_sub_ok) begin
               o_ctrl.rs_re  = 1'b1;
               o_ctrl.rt_re  = 1'b1;
               o_ctrl.rf_we  = 1'b1;
               o_ctrl.nzp_we = 1'b1;
               o_ctrl.alu_op = alu_op_t'({opc == OPC_LOGIC, i_insn[4]});
            end
         end
         OPC_LDR: begin
            o_ctrl.rs_re   = 1'b1;
            o_ctrl.rf_we   = 1'b1;
            o_ctrl.nzp_we  = 1'b1;
            o_ctrl.is_load = 1'b1;
            o_ctrl.imm_sel = IMM_OFF6;
         end
         OPC_STR: begin
            o_ctrl.rs_re    = 1'b1;
            o_ctrl.rt_sel   = i_insn[11:9]; // store data sits in the rd slot
            o_ctrl.rt_re    = 1'b1;
            o_ctrl.is_store = 1'b1;
            o_ctrl.imm_sel  = IMM_OFF6;
         end
         OPC_CONST: begin
            o_ctrl.rf_we   = 1'b1;
            o_ctrl.nzp_we  = 1'b1;
            o_ctrl.imm_sel = IMM_CONST9;
         end
         default: begin
            o_ctrl.rd_sel = '0; // unsupported, no writes
         end
      endcase
   end

endmodule

// ==== logic/lc4_regfile.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_regfile (
   input  logic                   gwe,
   input  logic                   i_reset,
   input  logic [`LC4_REG_W-1:0]  i_rs,
   input  logic [`LC4_REG_W-1:0]  i_rt,
   input  logic [`LC4_REG_W-1:0]  i_rd,
   input  logic                   i_we,
   input  logic [`LC4_WORD_W-1:0] i_wdata,
   output logic [`LC4_WORD_W-1:0] o_rs_data,
   output logic [`LC4_WORD_W-1:0] o_rt_data
);

   logic [`LC4_WORD_W-1:0] regs [`LC4_NUM_REGS];

   // no write-through, a writeback value shows up the cycle after
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < `LC4_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   assign o_rs_data = regs[i_rs];
   assign o_rt_data = regs[i_rt];

endmodule

// ==== logic/lc4_hazard_unit.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_hazard_unit
   import lc4_pkg::*;
(
   input  ctrl_t i_dec,
   input  ctrl_t i_ex,
   input  ctrl_t i_mem,
   input  ctrl_t i_wb,
   output logic  o_stall
);

   logic rs_hit;
   logic rt_hit;
   logic nzp_busy;

   // true when slot c will write register sel
   function automatic logic writes_reg(input ctrl_t c, input logic [`LC4_REG_W-1:0] sel);
      return c.rf_we && (c.rd_sel == sel);
   endfunction

   // nothing is bypassed, so any writer still in flight blocks the reader
   assign rs_hit = i_dec.rs_re && (writes_reg(i_ex, i_dec.rs_sel) ||
                                   writes_reg(i_mem, i_dec.rs_sel) ||
                                   writes_reg(i_wb, i_dec.rs_sel));

   assign rt_hit = i_dec.rt_re && (writes_reg(i_ex, i_dec.rt_sel) ||
                                   writes_reg(i_mem, i_dec.rt_sel) ||
                                   writes_reg(i_wb, i_dec.rt_sel));

   // a branch must see the nzp of every older instruction
   assign nzp_busy = i_ex.nzp_we | i_mem.nzp_we | i_wb.nzp_we;

   assign o_stall = rs_hit | rt_hit | (i_dec.is_branch & nzp_busy);

endmodule

// ==== logic/lc4_execute.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_execute
   import lc4_pkg::*;
(
   input  logic                   gwe,
   input  logic                   i_reset,
   input  stage_t                 i_slot,     // value carries rt here
   input  logic [`LC4_WORD_W-1:0] i_rs_data,
   input  logic                   i_nzp_we,   // from writeback
   input  logic [2:0]             i_nzp_bits,
   output logic [`LC4_WORD_W-1:0] o_result,
   output logic                   o_taken,
   output logic [`LC4_WORD_W-1:0] o_target
);

   logic [2:0]             nzp_q;
   logic [`LC4_WORD_W-1:0] imm6;
   logic [`LC4_WORD_W-1:0] imm9;
   logic [`LC4_WORD_W-1:0] opnd_b;
   logic [`LC4_WORD_W-1:0] alu_out;

   assign imm6 = {{(`LC4_WORD_W-6){i_slot.insn[5]}}, i_slot.insn[5:0]};
   assign imm9 = {{(`LC4_WORD_W-9){i_slot.insn[8]}}, i_slot.insn[8:0]};

   // loads and stores reuse the adder for base + offset
   assign opnd_b = (i_slot.ctrl.imm_sel == IMM_OFF6) ? imm6 : i_slot.value;

   always_comb begin
      case (i_slot.ctrl.alu_op)
         ALU_ADD: alu_out = i_rs_data + opnd_b;
         ALU_SUB: alu_out = i_rs_data - opnd_b;
         ALU_AND: alu_out = i_rs_data & opnd_b;
         ALU_OR:  alu_out = i_rs_data | opnd_b;
         default: alu_out = '0;
      endcase
   end

   assign o_result = (i_slot.ctrl.imm_sel == IMM_CONST9) ? imm9 : alu_out;

   // condition register, architectural state updated at retire
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         nzp_q <= 3'b010;
      end else if (i_nzp_we) begin
         nzp_q <= i_nzp_bits;
      end
   end

   // mask in insn[11:9] is n, z, p
   assign o_taken  = i_slot.ctrl.is_branch & (|(i_slot.insn[11:9] & nzp_q));
   assign o_target = i_slot.pc + imm9 + 1'b1;

endmodule

// ==== logic/lc4_pipeline.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_pipeline
   import lc4_pkg::*;
(
   input  logic                   gwe,
   input  logic                   i_reset,
   output logic [`LC4_WORD_W-1:0] o_cur_pc,
   input  logic [`LC4_WORD_W-1:0] i_cur_insn,
   output logic [`LC4_WORD_W-1:0] o_dmem_addr,
   output logic                   o_dmem_we,
   output logic [`LC4_WORD_W-1:0] o_dmem_towrite,
   input  logic [`LC4_WORD_W-1:0] i_cur_dmem_data,
   output wb_trace_t              o_trace
);

   localparam stage_t FLUSH_SLOT = '{pc: '0, insn: '0, ctrl: '0,
                                     stall: STALL_FLUSH, value: '0};
   localparam stage_t HAZARD_SLOT = '{pc: '0, insn: '0, ctrl: '0,
                                      stall: STALL_HAZARD, value: '0};

   stage_t dec_q, ex_q, mem_q, wb_q;
   stage_t fetch_slot, dec_slot, ex_slot, mem_slot;

   ctrl_t                  dec_ctrl;
   logic                   stall;
   logic                   taken;
   logic [`LC4_WORD_W-1:0] target;
   logic [`LC4_WORD_W-1:0] pc;
   logic [`LC4_WORD_W-1:0] rs_data, rt_data;
   logic [`LC4_WORD_W-1:0] ex_rs;        // rs operand beside the execute slot
   logic [`LC4_WORD_W-1:0] ex_result;
   logic [`LC4_WORD_W-1:0] mem_rt;       // store data in the memory stage
   logic [`LC4_WORD_W-1:0] wb_dmem_addr;
   logic [`LC4_WORD_W-1:0] wb_dmem_data;
   logic [2:0]             wb_nzp;
   logic                   mem_access;

   lc4_pc_counter i_lc4_pc_counter (
      .gwe        (gwe),
      .i_reset    (i_reset),
      .i_stall    (stall),
      .i_redirect (taken),
      .i_target   (target),
      .o_pc       (pc)
   );

   assign o_cur_pc = pc;

   lc4_decoder i_lc4_decoder (
      .i_insn (dec_q.insn),
      .o_ctrl (dec_ctrl)
   );

   lc4_regfile i_lc4_regfile (
      .gwe       (gwe),
      .i_reset   (i_reset),
      .i_rs      (dec_ctrl.rs_sel),
      .i_rt      (dec_ctrl.rt_sel),
      .i_rd      (wb_q.ctrl.rd_sel),
      .i_we      (wb_q.ctrl.rf_we),
      .i_wdata   (wb_q.value),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   lc4_hazard_unit i_lc4_hazard_unit (
      .i_dec   (dec_ctrl),
      .i_ex    (ex_q.ctrl),
      .i_mem   (mem_q.ctrl),
      .i_wb    (wb_q.ctrl),
      .o_stall (stall)
   );

   lc4_execute i_lc4_execute (
      .gwe        (gwe),
      .i_reset    (i_reset),
      .i_slot     (ex_q),
      .i_rs_data  (ex_rs),
      .i_nzp_we   (wb_q.ctrl.nzp_we),
      .i_nzp_bits (wb_nzp),
      .o_result   (ex_result),
      .o_taken    (taken),
      .o_target   (target)
   );

   // memory stage drives the data port directly from its slot
   assign mem_access     = mem_q.ctrl.is_load | mem_q.ctrl.is_store;
   assign o_dmem_addr    = mem_access ? mem_q.value : '0;
   assign o_dmem_we      = mem_q.ctrl.is_store;
   assign o_dmem_towrite = mem_rt;

   always_comb begin
      fetch_slot       = '{pc: pc, insn: i_cur_insn, ctrl: '0,
                           stall: STALL_NONE, value: '0};
      dec_slot         = dec_q;
      dec_slot.ctrl    = dec_ctrl;
      dec_slot.value   = rt_data;
      ex_slot          = ex_q;
      ex_slot.value    = ex_result;
      mem_slot         = mem_q;
      mem_slot.value   = mem_q.ctrl.is_load ? i_cur_dmem_data : mem_q.value;
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         dec_q <= FLUSH_SLOT;
         ex_q  <= FLUSH_SLOT;
         mem_q <= FLUSH_SLOT;
         wb_q  <= FLUSH_SLOT;
      end else begin
         // a taken branch squashes the two younger slots
         if (taken) begin
            dec_q <= FLUSH_SLOT;
            ex_q  <= FLUSH_SLOT;
         end else if (stall) begin
            ex_q  <= HAZARD_SLOT; // decode holds its instruction
         end else begin
            dec_q <= fetch_slot;
            ex_q  <= dec_slot;
         end
         mem_q <= ex_slot;
         wb_q  <= mem_slot;
      end
   end

   always_ff @(posedge gwe) begin
      ex_rs        <= rs_data;
      mem_rt       <= ex_q.value;
      wb_dmem_addr <= o_dmem_addr;
      wb_dmem_data <= mem_q.ctrl.is_load  ? i_cur_dmem_data :
                      mem_q.ctrl.is_store ? mem_rt : '0;
   end

   assign wb_nzp = nzp_of(wb_q.value);

   always_comb begin
      o_trace.stall        = wb_q.stall;
      o_trace.pc           = wb_q.pc;
      o_trace.insn         = wb_q.insn;
      o_trace.regfile_we   = wb_q.ctrl.rf_we;
      o_trace.regfile_wsel = wb_q.ctrl.rd_sel;
      o_trace.regfile_data = wb_q.value;
      o_trace.nzp_we       = wb_q.ctrl.nzp_we;
      o_trace.nzp_bits     = wb_nzp;
      o_trace.dmem_we      = wb_q.ctrl.is_store;
      o_trace.dmem_addr    = wb_dmem_addr;
      o_trace.dmem_data    = wb_dmem_data;
   end

endmodule

// ==== verification/lc4_asserts.sv ====
`timescale 1ns/1ps

module lc4_asserts
   import lc4_pkg::*;
(
   input logic      gwe,
   input logic      i_reset,
   input logic      i_dmem_we,
   input wb_trace_t i_trace
);

   // bubbles never write anything
   a_bubble_quiet: assert property (@(posedge gwe) disable iff (i_reset)
      (i_trace.stall != STALL_NONE) |->
         !(i_trace.regfile_we | i_trace.nzp_we | i_trace.dmem_we))
      else $error("bubble in writeback carries a write enable");

   // once reset has been seen for a cycle no store may leave the pipeline
   a_reset_no_store: assert property (@(posedge gwe)
      (i_reset && $past(i_reset)) |-> !i_dmem_we)
      else $error("data memory write during reset");

   a_legal_stall: assert property (@(posedge gwe) disable iff (i_reset)
      i_trace.stall inside {STALL_NONE, STALL_FLUSH, STALL_HAZARD})
      else $error("illegal stall code in trace");

endmodule

// ==== verification/lc4_tb.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_tb
   import lc4_pkg::*;
();

   logic gwe = 1'b0;
   logic i_reset = 1'b1;
   logic [15:0] o_cur_pc, i_cur_insn, o_dmem_addr, o_dmem_towrite, i_cur_dmem_data;
   logic o_dmem_we;
   wb_trace_t o_trace;

   logic [15:0] imem [0:127];
   logic [15:0] dmem [0:65535];
   logic [15:0] mem_model [0:65535];
   logic [15:0] reg_model [0:7];
   logic [15:0] mpc = `LC4_BOOT_PC;  // model pc
   logic [2:0]  mnzp = 3'b010;
   logic [15:0] lfsr = 16'd82;
   logic [15:0] end_pc;
   int          n_insn = 0;
   int          cycles = 0;
   int          hazards = 0;
   int          flushes = 0;
   logic        started = 1'b0;   // first instruction retired
   logic        done = 1'b0;

   lc4_pipeline i_lc4_pipeline (.*);

   bind lc4_pipeline lc4_asserts i_lc4_asserts (.gwe(gwe), .i_reset(i_reset),
      .i_dmem_we(o_dmem_we), .i_trace(o_trace));

   initial begin
      forever #20 gwe = ~gwe;
   end

   function automatic logic [15:0] fetch_word(input logic [15:0] addr);
      logic [15:0] idx;
      idx = addr - `LC4_BOOT_PC;
      return (idx < 128) ? imem[idx[6:0]] : 16'h0000;
   endfunction

   assign i_cur_insn      = fetch_word(o_cur_pc);
   assign i_cur_dmem_data = dmem[o_dmem_addr];

   always @(posedge gwe) begin
      if (o_dmem_we) dmem[o_dmem_addr] <= o_dmem_towrite;
   end

   // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] r;
      logic        b;
      r = '0;
      for (int i = 0; i < n; i++) begin
         b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], b};
         r = {r[14:0], b};
      end
      return r;
   endfunction

   function automatic logic [2:0] pick_reg();
      logic [2:0] r;
      r = 3'(rand_bits(3));
      return (r == 3'd7) ? 3'd0 : r;   // r7 stays the memory base
   endfunction

   function automatic logic [15:0] rrr(input logic [3:0] op, input logic [2:0] sub,
                                       input logic [2:0] d, s, t);
      return {op, d, s, sub, t};
   endfunction

   task automatic put(input logic [15:0] w);
      imem[n_insn] = w;
      n_insn++;
   endtask

   function automatic logic [2:0] sign_class(input logic [15:0] v);
      return v[15] ? 3'b100 : (v == 0) ? 3'b010 : 3'b001;
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [15:0] got, exp);
      assert (got === exp) else
         stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   endtask

   // program with fixed dependence and branch cases followed by a random tail
   initial begin
      logic [2:0] k;
      for (int a = 0; a < 65536; a++) begin
         dmem[a] = {a[7:0], a[15:8]} ^ 16'h3c5a;
         if (a >= 16'h40 && a < 16'h50) dmem[a] = rand_bits(16);
         mem_model[a] = dmem[a];
      end
      for (int i = 0; i < 128; i++) imem[i] = '0;
      for (int r = 0; r < 7; r++) put({4'h9, 3'(r), 9'(rand_bits(9))});
      put({4'h9, 3'd7, 9'h040});
      put(rrr(4'h1, 3'b000, 3'd1, 3'd0, 3'd2));   // back to back chain
      put(rrr(4'h1, 3'b010, 3'd3, 3'd1, 3'd4));
      put(rrr(4'h5, 3'b000, 3'd5, 3'd3, 3'd0));
      put(rrr(4'h5, 3'b010, 3'd6, 3'd5, 3'd1));
      put({4'h6, 3'd2, 3'd7, 6'd3});              // load-use
      put(rrr(4'h1, 3'b000, 3'd4, 3'd2, 3'd2));
      put({4'h7, 3'd4, 3'd7, 6'd5});
      put({4'h6, 3'd1, 3'd7, 6'd5});
      put(rrr(4'h1, 3'b010, 3'd0, 3'd1, 3'd4));   // zero result
      put({4'h0, 3'b010, 9'd2});                  // taken and skips two
      put({4'h9, 3'd5, 9'd1});
      put({4'h9, 3'd6, 9'd2});
      put({4'h0, 3'b101, 9'd1});                  // not taken
      put({4'h9, 3'd3, 9'h1ff});
      put({4'h0, 3'b100, 9'd1});                  // taken on negative
      put({4'h9, 3'd3, 9'd7});
      for (int i = 0; i < 14; i++) begin
         k = 3'(rand_bits(3));
         case (k)
            3'd0, 3'd1: put(rrr(4'h1, {1'b0, k[0], 1'b0}, pick_reg(), pick_reg(), pick_reg()));
            3'd2, 3'd3: put(rrr(4'h5, {1'b0, k[0], 1'b0}, pick_reg(), pick_reg(), pick_reg()));
            3'd4: put({4'h9, pick_reg(), 9'(rand_bits(9))});
            3'd5: put({4'h7, pick_reg(), 3'd7, 2'b00, 4'(rand_bits(4))});
            3'd6: put({4'h6, pick_reg(), 3'd7, 2'b00, 4'(rand_bits(4))});
            default: begin
               put({4'h0, 3'(rand_bits(3)), 8'd0, 1'(rand_bits(1))});
               put({4'h9, pick_reg(), 9'(rand_bits(9))});
               put({4'h9, pick_reg(), 9'(rand_bits(9))});
            end
         endcase
      end
      put(rrr(4'h1, 3'b000, 3'd0, 3'd1, 3'd2));
      end_pc = `LC4_BOOT_PC + 16'(n_insn);
   end

   initial begin
      repeat (16) @(posedge gwe);
      i_reset <= 1'b0;
      wait (done);
      if (hazards == 0) begin
         stop_with_failure("no hazard bubble was seen between dependent instructions");
      end else if (flushes == 0) begin
         stop_with_failure("no flush bubble was seen after a taken branch");
      end else begin
         $display("No errors");
         $finish;
      end
   end

   always @(posedge gwe) begin
      cycles <= cycles + 1;
      if (cycles >= `LC4_RUN_LIMIT)
         stop_with_failure("timeout, the program did not finish within the cycle limit");
   end

   // retire one instruction in the model and compare with the trace
   task automatic retire(input wb_trace_t t);
      logic [15:0] insn, a, b, addr, value, next;
      logic [15:0] off6, imm9;
      logic        we, st, ld;
      insn = fetch_word(mpc);
      a = reg_model[insn[8:6]];
      b = reg_model[insn[2:0]];
      off6 = {{10{insn[5]}}, insn[5:0]};
      imm9 = {{7{insn[8]}}, insn[8:0]};
      addr = a + off6;
      value = '0;
      next = mpc + 1;
      we = 1'b0;
      st = 1'b0;
      ld = 1'b0;
      check_value("trace.pc", t.pc, mpc);
      check_value("trace.insn", t.insn, insn);
      case (insn[15:12])
         4'h0: if ((insn[11:9] & mnzp) != 0) next = mpc + 1 + imm9;
         4'h1: begin
            we = (insn[5:3] == 3'b000) || (insn[5:3] == 3'b010);
            value = insn[4] ? a - b : a + b;
         end
         4'h5: begin
            we = (insn[5:3] == 3'b000) || (insn[5:3] == 3'b010);
            value = insn[4] ? a | b : a & b;
         end
         4'h6: begin
            we = 1'b1;
            ld = 1'b1;
            value = mem_model[addr];
            check_value("trace.dmem_addr", t.dmem_addr, addr);
            check_value("trace.dmem_data", t.dmem_data, value);
         end
         4'h7: begin
            st = 1'b1;
            check_value("trace.dmem_addr", t.dmem_addr, addr);
            check_value("trace.dmem_data", t.dmem_data, reg_model[insn[11:9]]);
            mem_model[addr] = reg_model[insn[11:9]];
         end
         4'h9: begin
            we = 1'b1;
            value = imm9;
         end
         default: ;
      endcase
      if (!ld && !st) begin
         // no memory access shows as zero address and data
         check_value("trace.dmem_addr", t.dmem_addr, 16'h0000);
         check_value("trace.dmem_data", t.dmem_data, 16'h0000);
      end
      check_value("trace.regfile_we", 16'(t.regfile_we), 16'(we));
      check_value("trace.nzp_we", 16'(t.nzp_we), 16'(we));
      check_value("trace.dmem_we", 16'(t.dmem_we), 16'(st));
      if (we) begin
         check_value("trace.regfile_wsel", 16'(t.regfile_wsel), 16'(insn[11:9]));
         check_value("trace.regfile_data", t.regfile_data, value);
         check_value("trace.nzp_bits", 16'(t.nzp_bits), 16'(sign_class(value)));
         reg_model[insn[11:9]] = value;
         mnzp = sign_class(value);
      end
      mpc = next;
   endtask

   // outputs are stable at the falling edge
   always @(negedge gwe) begin
      if (i_reset && cycles > 0) begin
         check_value("trace.regfile_we", 16'(o_trace.regfile_we), 16'h0);
         check_value("trace.nzp_we", 16'(o_trace.nzp_we), 16'h0);
         check_value("trace.dmem_we", 16'(o_trace.dmem_we), 16'h0);
         check_value("o_dmem_we", 16'(o_dmem_we), 16'h0);
         for (int r = 0; r < 8; r++) reg_model[r] = '0;
      end else if (!i_reset && !done) begin
         if (o_trace.stall == STALL_NONE) begin
            retire(o_trace);
            started = 1'b1;
            if (mpc >= end_pc) done = 1'b1;
         end else if (started && o_trace.stall == STALL_HAZARD) begin
            hazards++;
         end else if (started && o_trace.stall == STALL_FLUSH) begin
            flushes++;
         end
      end
   end

endmodule

// ==== tb.f ====
+incdir+logic
logic/lc4_pkg.sv
logic/lc4_pc_counter.sv
logic/lc4_decoder.sv
logic/lc4_regfile.sv
logic/lc4_hazard_unit.sv
logic/lc4_execute.sv
logic/lc4_pipeline.sv
verification/lc4_asserts.sv
verification/lc4_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lc4 pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f tb.f --top-module lc4_tb -o lc4_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/lc4_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "No errors" sim.log; then
   exit 0
fi
exit 1
